// File: files.f
+incdir+verification
logic/mgmt_regmap_pkg.sv
logic/bert_lane_pkg.sv
logic/mgmt_addr_decoder.sv
logic/bert_lane_regs.sv
logic/crossbar_ctrl_regs.sv
logic/mgmt_read_mux.sv
logic/mgmt_register_block.sv
verification/tb_mgmt_register_block.sv

// File: logic/bert_lane_pkg.sv
package bert_lane_pkg;

	//////////////////////
	// Lane geometry

	localparam int NUM_LANES = 2;

	// PRBS select as the transceiver expects it
	localparam int PRBS_W = 3;

	// Dynamic reconfiguration port
	localparam int DRP_ADDR_W = 9;
	localparam int DRP_DATA_W = 16;

	// Output clock divider select
	localparam int CLKDIV_W = 3;

	// Trigger mux selector
	localparam int MUXSEL_W = 4;

	// TX driver fields
	localparam int SWING_W  = 4;
	localparam int CURSOR_W = 5;

	//////////////////////
	// Lane config words

	typedef struct packed {
		logic [PRBS_W-1:0]   prbsmode;
		logic [SWING_W-1:0]  swing;
		logic [CURSOR_W-1:0] precursor;
		logic [CURSOR_W-1:0] postcursor;
		logic                enable;
		logic                invert;
		logic [CLKDIV_W-1:0] clkdiv;
		logic                clk_from_qpll;
		logic                tx_reset;
	} lane_txconfig_t;

	typedef struct packed {
		logic [PRBS_W-1:0]   prbsmode;
		logic [CLKDIV_W-1:0] clkdiv;
		logic                clk_from_qpll;
		logic                pmareset;
		logic                rx_reset;
		logic                invert;
	} lane_rxconfig_t;

	// TX driver word, filled as two bus bytes and used as driver fields
	typedef union packed {
		logic [1:0][7:0] bytes;
		struct packed {
			logic                invert;
			logic                enable;
			logic [CURSOR_W-1:0] postcursor;
			logic [CURSOR_W-1:0] precursor;
			logic [SWING_W-1:0]  swing;
		} fields;
	} lane_tx_word_u;

endpackage

// File: logic/bert_lane_regs.sv
`timescale 1ns/1ps

module bert_lane_regs
	import mgmt_regmap_pkg::*, bert_lane_pkg::*;
(
	input  logic                     clk,
	input  logic                     rst,

	// Writes already decoded to this lane
	input  logic                     wr_en,
	input  logic [LANE_OFFSET_W-1:0] wr_offset,
	input  logic [MGMT_DATA_W-1:0]   wr_data,

	// Combinational read back
	input  logic [LANE_OFFSET_W-1:0] rd_offset,
	output logic [MGMT_DATA_W-1:0]   rd_byte,

	// Transceiver configuration
	output lane_txconfig_t           tx_config,
	output lane_rxconfig_t           rx_config,
	output logic                     config_updated,

	// Dynamic reconfiguration port
	output logic                     drp_en,
	output logic                     drp_we,
	output logic [DRP_ADDR_W-1:0]    drp_addr,
	output logic [DRP_DATA_W-1:0]    drp_wdata,
	input  logic [DRP_DATA_W-1:0]    drp_rdata,
	input  logic                     drp_done,
	input  logic                     rx_rstdone
);

	lane_tx_word_u         tx_word;
	logic [PRBS_W-1:0]     tx_prbsmode;
	logic [CLKDIV_W-1:0]   tx_clkdiv;
	logic                  tx_clk_from_qpll;
	logic                  tx_reset;
	logic                  drp_busy;
	logic [DRP_DATA_W-1:0] drp_rdata_q;

	// TX side gathered from the driver word and its own fields
	always_comb begin
		tx_config.prbsmode      = tx_prbsmode;
		tx_config.swing         = tx_word.fields.swing;
		tx_config.precursor     = tx_word.fields.precursor;
		tx_config.postcursor    = tx_word.fields.postcursor;
		tx_config.enable        = tx_word.fields.enable;
		tx_config.invert        = tx_word.fields.invert;
		tx_config.clkdiv        = tx_clkdiv;
		tx_config.clk_from_qpll = tx_clk_from_qpll;
		tx_config.tx_reset      = tx_reset;
	end

	//////////////////////
	// Config registers

	always_ff @(posedge clk) begin
		config_updated <= 1'b0;
		drp_en         <= 1'b0;

		if (rst) begin
			tx_word          <= '0;
			tx_prbsmode      <= '0;
			tx_clkdiv        <= '0;
			tx_clk_from_qpll <= 1'b0;
			tx_reset         <= 1'b0;
			rx_config        <= '0;
		end else if (wr_en) begin
			case (wr_offset)
				// RX mode low nibble, TX mode high nibble
				LANE_REG_PRBS: begin
					rx_config.prbsmode <= wr_data[PRBS_W-1:0];
					tx_prbsmode        <= wr_data[4 +: PRBS_W];
					config_updated     <= 1'b1;
				end

				// Low byte only stages, high byte commits the driver word
				LANE_REG_TX:
					tx_word.bytes[0] <= wr_data;
				LANE_REG_TX_1: begin
					tx_word.bytes[1] <= wr_data;
					config_updated   <= 1'b1;
				end

				LANE_REG_CLK: begin
					tx_clkdiv               <= wr_data[CLKDIV_W-1:0];
					tx_clk_from_qpll        <= wr_data[3];
					rx_config.clkdiv        <= wr_data[4 +: CLKDIV_W];
					rx_config.clk_from_qpll <= wr_data[7];
					config_updated          <= 1'b1;
				end

				LANE_REG_RST: begin
					rx_config.pmareset <= wr_data[0];
					tx_reset           <= wr_data[1];
					rx_config.rx_reset <= wr_data[2];
					config_updated     <= 1'b1;
				end

				LANE_REG_RX: begin
					rx_config.invert <= wr_data[0];
					config_updated   <= 1'b1;
				end

				// High address byte launches the DRP access
				LANE_REG_AD_1:
					drp_en <= 1'b1;

				default: begin
				end
			endcase
		end
	end

	//////////////////////
	// DRP transaction

	// Write data goes first, then the address bytes
	always_ff @(posedge clk) begin
		if (wr_en) begin
			case (wr_offset)
				LANE_REG_WD:   drp_wdata[7:0]  <= wr_data;
				LANE_REG_WD_1: drp_wdata[15:8] <= wr_data;
				LANE_REG_AD:   drp_addr[7:0]   <= wr_data;
				LANE_REG_AD_1: begin
					drp_we                <= wr_data[7];
					drp_addr[DRP_ADDR_W-1] <= wr_data[0];
				end
				default: begin
				end
			endcase
		end

		// Hold read data until the next access completes
		if (drp_done)
			drp_rdata_q <= drp_rdata;
	end

	// Busy from launch until the transceiver answers
	always_ff @(posedge clk) begin
		if (rst)
			drp_busy <= 1'b0;
		else if (drp_en)
			drp_busy <= 1'b1;
		else if (drp_done)
			drp_busy <= 1'b0;
	end

	// Launch cycle already counts as busy
	always_comb begin
		case (rd_offset)
			LANE_REG_RD:   rd_byte = drp_rdata_q[7:0];
			LANE_REG_RD_1: rd_byte = drp_rdata_q[15:8];
			LANE_REG_STAT: rd_byte = {6'b0, rx_rstdone, drp_busy | drp_en};
			default:       rd_byte = '0;
		endcase
	end

	// Transceiver only answers an access this lane started
	assert property (@(posedge clk) disable iff (rst) drp_done |-> drp_busy);

endmodule

// File: logic/crossbar_ctrl_regs.sv
`timescale 1ns/1ps

module crossbar_ctrl_regs
	import mgmt_regmap_pkg::*, bert_lane_pkg::*;
(
	input  logic                       clk,
	input  logic                       rst,

	// Writes already decoded to the crossbar region
	input  logic                       wr_en,
	input  logic [REG_OFFSET_W-1:0]    wr_offset,
	input  logic [MGMT_DATA_W-1:0]     wr_data,

	input  logic [REG_OFFSET_W-1:0]    rd_offset,
	output logic [MGMT_DATA_W-1:0]     rd_byte,

	// Trigger mux selectors
	output logic [MUXSEL_W-1:0]        muxsel [NUM_MUX_CHANNELS],

	// Relay driver
	output logic                       relay_en,
	output logic                       relay_dir,
	output logic [RELAY_CHANNEL_W-1:0] relay_channel,
	input  logic                       relay_done
);

	logic [RELAY_CHANNEL_W-1:0] channel_staged;
	logic                       relay_busy;
	logic                       relay_active;
	logic                       toggle_wr;

	// Launch cycle counts as busy for status and for new toggles
	assign relay_active = relay_busy | relay_en;
	assign toggle_wr = wr_en && (wr_offset == REG_RELAY_TOGGLE_1[REG_OFFSET_W-1:0]);

	//////////////////////
	// Selector bank

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < NUM_MUX_CHANNELS; i++)
				muxsel[i] <= '0;
		end else if (wr_en) begin
			for (int i = 0; i < NUM_MUX_CHANNELS; i++) begin
				if (wr_offset == REG_MUXSEL_BASE[REG_OFFSET_W-1:0] + REG_OFFSET_W'(i))
					muxsel[i] <= wr_data[MUXSEL_W-1:0];
			end
		end
	end

	//////////////////////
	// Relay toggles

	always_ff @(posedge clk) begin
		relay_en <= 1'b0;

		if (rst) begin
			relay_busy     <= 1'b0;
			relay_dir      <= 1'b0;
			relay_channel  <= '0;
			channel_staged <= '0;
		end else begin
			if (relay_done)
				relay_busy <= 1'b0;
			if (relay_en)
				relay_busy <= 1'b1;

			// Channel may be staged at any time, outputs move only on launch
			if (wr_en && (wr_offset == REG_RELAY_TOGGLE[REG_OFFSET_W-1:0]))
				channel_staged <= wr_data[RELAY_CHANNEL_W-1:0];

			// Toggles during a move are dropped
			if (toggle_wr && !relay_active) begin
				relay_en      <= 1'b1;
				relay_dir     <= wr_data[7];
				relay_channel <= channel_staged;
			end
		end
	end

	always_comb begin
		rd_byte = '0;
		case (rd_offset)
			// Low status byte is reserved
			REG_RELAY_STAT[REG_OFFSET_W-1:0]:
				rd_byte = '0;
			REG_RELAY_STAT_1[REG_OFFSET_W-1:0]:
				rd_byte = {{(MGMT_DATA_W-1){1'b0}}, relay_active};
			default: begin
				for (int i = 0; i < NUM_MUX_CHANNELS; i++) begin
					if (rd_offset == REG_MUXSEL_BASE[REG_OFFSET_W-1:0] + REG_OFFSET_W'(i))
						rd_byte = {{(MGMT_DATA_W-MUXSEL_W){1'b0}}, muxsel[i]};
				end
			end
		endcase
	end

	// A relay move never starts while the previous one is still in flight
	assert property (@(posedge clk) disable iff (rst) relay_en |-> !relay_busy);

endmodule

// File: logic/mgmt_addr_decoder.sv
`timescale 1ns/1ps

module mgmt_addr_decoder
	import mgmt_regmap_pkg::*, bert_lane_pkg::*;
(
	input  logic                    clk,
	input  logic                    rst,

	// Host bus access, same cycle
	input  logic                    rd_en,
	input  logic [MGMT_ADDR_W-1:0]  rd_addr,
	input  logic                    wr_en,
	input  logic [MGMT_ADDR_W-1:0]  wr_addr,

	// Region selects
	output logic [NUM_LANES-1:0]    lane_wr_en,
	output logic                    xbar_wr_en,
	output logic [REG_OFFSET_W-1:0] wr_offset,
	output rd_src_t                 rd_src,
	output logic [REG_OFFSET_W-1:0] rd_offset
);

	// Lane window hit, upper address bits against the aligned base
	function automatic logic in_lane(input logic [MGMT_ADDR_W-1:0] addr, input int lane);
		logic [MGMT_ADDR_W-1:0] base;
		base = LANE_BASE[lane];
		return addr[MGMT_ADDR_W-1:LANE_OFFSET_W] == base[MGMT_ADDR_W-1:LANE_OFFSET_W];
	endfunction

	// Crossbar region is the relay block plus the selector bank
	function automatic logic in_xbar(input logic [MGMT_ADDR_W-1:0] addr);
		logic relay_hit;
		logic muxsel_hit;
		relay_hit = (addr >= REG_RELAY_TOGGLE) && (addr <= REG_RELAY_STAT_1);
		muxsel_hit = (addr >= REG_MUXSEL_BASE) &&
			(addr < REG_MUXSEL_BASE + MGMT_ADDR_W'(NUM_MUX_CHANNELS));
		return relay_hit || muxsel_hit;
	endfunction

	// Regions decode on the low byte from here on
	assign wr_offset = wr_addr[REG_OFFSET_W-1:0];
	assign rd_offset = rd_addr[REG_OFFSET_W-1:0];

	assign xbar_wr_en = wr_en && in_xbar(wr_addr);

	always_comb begin
		lane_wr_en = '0;

		// Anything not claimed below reads back as zero
		rd_src = RD_SRC_NONE;

		for (int i = 0; i < NUM_LANES; i++) begin
			if (wr_en && in_lane(wr_addr, i))
				lane_wr_en[i] = 1'b1;
			if (rd_en && in_lane(rd_addr, i))
				rd_src = rd_src_t'(i);
		end

		if (rd_en && in_xbar(rd_addr))
			rd_src = RD_SRC_XBAR;
	end

	// A write lands in at most one region
	assert property (@(posedge clk) disable iff (rst) $onehot0({lane_wr_en, xbar_wr_en}));

endmodule

// File: logic/mgmt_read_mux.sv
`timescale 1ns/1ps

module mgmt_read_mux
	import mgmt_regmap_pkg::*, bert_lane_pkg::*;
(
	input  logic                   clk,
	input  logic                   rst,

	// Read strobe and decoded source, same cycle
	input  logic                   rd_en,
	input  rd_src_t                rd_src,

	// Combinational bytes from every region
	input  logic [MGMT_DATA_W-1:0] lane_rd_byte [NUM_LANES],
	input  logic [MGMT_DATA_W-1:0] xbar_rd_byte,

	// Host side, one cycle after rd_en
	output logic                   rd_valid,
	output logic [MGMT_DATA_W-1:0] rd_data
);

	logic [MGMT_DATA_W-1:0] rd_sel;

	// Unmapped reads return zero
	always_comb begin
		case (rd_src)
			RD_SRC_LANE0: rd_sel = lane_rd_byte[0];
			RD_SRC_LANE1: rd_sel = lane_rd_byte[1];
			RD_SRC_XBAR:  rd_sel = xbar_rd_byte;
			default:      rd_sel = '0;
		endcase
	end

	//////////////////////
	// Response register

	// Single cycle valid, no back-pressure
	always_ff @(posedge clk) begin
		if (rst)
			rd_valid <= 1'b0;
		else
			rd_valid <= rd_en;
	end

	// Data held until the next read
	always_ff @(posedge clk) begin
		if (rd_en)
			rd_data <= rd_sel;
	end

endmodule

// File: logic/mgmt_register_block.sv
`timescale 1ns/1ps

module mgmt_register_block
	import mgmt_regmap_pkg::*, bert_lane_pkg::*;
(
	input  logic                       clk,
	input  logic                       rst,

	// Host byte bus
	input  logic                       rd_en,
	input  logic [MGMT_ADDR_W-1:0]     rd_addr,
	output logic                       rd_valid,
	output logic [MGMT_DATA_W-1:0]     rd_data,
	input  logic                       wr_en,
	input  logic [MGMT_ADDR_W-1:0]     wr_addr,
	input  logic [MGMT_DATA_W-1:0]     wr_data,

	// Per lane transceiver config
	output lane_txconfig_t             tx_config [NUM_LANES],
	output lane_rxconfig_t             rx_config [NUM_LANES],
	output logic [NUM_LANES-1:0]       config_updated,

	// Per lane DRP
	output logic [NUM_LANES-1:0]       drp_en,
	output logic [NUM_LANES-1:0]       drp_we,
	output logic [DRP_ADDR_W-1:0]      drp_addr [NUM_LANES],
	output logic [DRP_DATA_W-1:0]      drp_wdata [NUM_LANES],
	input  logic [DRP_DATA_W-1:0]      drp_rdata [NUM_LANES],
	input  logic [NUM_LANES-1:0]       drp_done,
	input  logic [NUM_LANES-1:0]       rx_rstdone,

	// Crossbar
	output logic [MUXSEL_W-1:0]        muxsel [NUM_MUX_CHANNELS],
	output logic                       relay_en,
	output logic                       relay_dir,
	output logic [RELAY_CHANNEL_W-1:0] relay_channel,
	input  logic                       relay_done
);

	logic [NUM_LANES-1:0]    lane_wr_en;
	logic                    xbar_wr_en;
	logic [REG_OFFSET_W-1:0] wr_offset;
	logic [REG_OFFSET_W-1:0] rd_offset;
	rd_src_t                 rd_src;
	logic [MGMT_DATA_W-1:0]  lane_rd_byte [NUM_LANES];
	logic [MGMT_DATA_W-1:0]  xbar_rd_byte;

	mgmt_addr_decoder u_decoder (
		.clk        (clk),
		.rst        (rst),
		.rd_en      (rd_en),
		.rd_addr    (rd_addr),
		.wr_en      (wr_en),
		.wr_addr    (wr_addr),
		.lane_wr_en (lane_wr_en),
		.xbar_wr_en (xbar_wr_en),
		.wr_offset  (wr_offset),
		.rd_src     (rd_src),
		.rd_offset  (rd_offset)
	);

	//////////////////////
	// Lane windows

	// Each lane sees only the offset bits of its window
	for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
		bert_lane_regs u_lane (
			.clk            (clk),
			.rst            (rst),
			.wr_en          (lane_wr_en[i]),
			.wr_offset      (wr_offset[LANE_OFFSET_W-1:0]),
			.wr_data        (wr_data),
			.rd_offset      (rd_offset[LANE_OFFSET_W-1:0]),
			.rd_byte        (lane_rd_byte[i]),
			.tx_config      (tx_config[i]),
			.rx_config      (rx_config[i]),
			.config_updated (config_updated[i]),
			.drp_en         (drp_en[i]),
			.drp_we         (drp_we[i]),
			.drp_addr       (drp_addr[i]),
			.drp_wdata      (drp_wdata[i]),
			.drp_rdata      (drp_rdata[i]),
			.drp_done       (drp_done[i]),
			.rx_rstdone     (rx_rstdone[i])
		);
	end

	crossbar_ctrl_regs u_xbar (
		.clk           (clk),
		.rst           (rst),
		.wr_en         (xbar_wr_en),
		.wr_offset     (wr_offset),
		.wr_data       (wr_data),
		.rd_offset     (rd_offset),
		.rd_byte       (xbar_rd_byte),
		.muxsel        (muxsel),
		.relay_en      (relay_en),
		.relay_dir     (relay_dir),
		.relay_channel (relay_channel),
		.relay_done    (relay_done)
	);

	mgmt_read_mux u_read_mux (
		.clk          (clk),
		.rst          (rst),
		.rd_en        (rd_en),
		.rd_src       (rd_src),
		.lane_rd_byte (lane_rd_byte),
		.xbar_rd_byte (xbar_rd_byte),
		.rd_valid     (rd_valid),
		.rd_data      (rd_data)
	);

endmodule

// File: logic/mgmt_regmap_pkg.sv
package mgmt_regmap_pkg;

	//////////////////////
	// Bus geometry

	// Byte wide registers behind a 16 bit address
	localparam int MGMT_ADDR_W = 16;
	localparam int MGMT_DATA_W = 8;

	// Low address byte, enough to reach any register inside one region
	localparam int REG_OFFSET_W = 8;

	//////////////////////
	// Serial lane windows

	// Windows are aligned to their size so the offset is just the low address bits
	localparam int LANE_WINDOW = 32;
	localparam int LANE_OFFSET_W = $clog2(LANE_WINDOW);

	// Element 0 is lane 0
	localparam logic [1:0][MGMT_ADDR_W-1:0] LANE_BASE = {16'h00a0, 16'h0080};

	// Offsets inside a lane window
	localparam logic [LANE_OFFSET_W-1:0] LANE_REG_PRBS = 5'h00;
	localparam logic [LANE_OFFSET_W-1:0] LANE_REG_TX   = 5'h02;
	localparam logic [LANE_OFFSET_W-1:0] LANE_REG_TX_1 = 5'h03;
	localparam logic [LANE_OFFSET_W-1:0] LANE_REG_WD   = 5'h04;
	localparam logic [LANE_OFFSET_W-1:0] LANE_REG_WD_1 = 5'h05;
	localparam logic [LANE_OFFSET_W-1:0] LANE_REG_AD   = 5'h06;
	localparam logic [LANE_OFFSET_W-1:0] LANE_REG_AD_1 = 5'h07;
	localparam logic [LANE_OFFSET_W-1:0] LANE_REG_RD   = 5'h08;
	localparam logic [LANE_OFFSET_W-1:0] LANE_REG_RD_1 = 5'h09;
	localparam logic [LANE_OFFSET_W-1:0] LANE_REG_STAT = 5'h0a;
	localparam logic [LANE_OFFSET_W-1:0] LANE_REG_CLK  = 5'h0c;
	localparam logic [LANE_OFFSET_W-1:0] LANE_REG_RST  = 5'h0e;
	localparam logic [LANE_OFFSET_W-1:0] LANE_REG_RX   = 5'h10;

	//////////////////////
	// Crossbar controls

	// Relay toggle is channel in the low byte, direction in bit 7 of the high byte
	localparam logic [MGMT_ADDR_W-1:0] REG_RELAY_TOGGLE   = 16'h0070;
	localparam logic [MGMT_ADDR_W-1:0] REG_RELAY_TOGGLE_1 = 16'h0071;
	localparam logic [MGMT_ADDR_W-1:0] REG_RELAY_STAT     = 16'h0072;
	localparam logic [MGMT_ADDR_W-1:0] REG_RELAY_STAT_1   = 16'h0073;
	localparam int RELAY_CHANNEL_W = 2;

	// One selector per trigger output, consecutive addresses
	localparam logic [MGMT_ADDR_W-1:0] REG_MUXSEL_BASE = 16'h00f0;
	localparam int NUM_MUX_CHANNELS = 12;

	// Region a read returns from, lane values match the lane index
	typedef enum logic [1:0] {
		RD_SRC_LANE0 = 2'd0,
		RD_SRC_LANE1 = 2'd1,
		RD_SRC_XBAR  = 2'd2,
		RD_SRC_NONE  = 2'd3
	} rd_src_t;

endpackage

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the register block testbench with Verilator
# Exit status is nonzero when the build fails or the testbench stops on an error

cd "$(dirname "$0")" || exit 1

verilator --binary --assert \
	-f files.f \
	--top-module tb_mgmt_register_block \
	-o sim_tb_mgmt_register_block \
	&& ./obj_dir/sim_tb_mgmt_register_block \
	|| { echo "simulation failed"; exit 1; }

// File: verification/tb_mgmt_checks.svh
`ifndef TB_MGMT_CHECKS_SVH
`define TB_MGMT_CHECKS_SVH

// Xorshift32, one step per call
function automatic logic [31:0] next_rand();
	rng_state = rng_state ^ (rng_state << 13);
	rng_state = rng_state ^ (rng_state >> 17);
	rng_state = rng_state ^ (rng_state << 5);
	return rng_state;
endfunction

//////////////////////
// Bus drive

// Present a write a little after the edge, it lands on the next edge
task automatic drive_write(input logic [MGMT_ADDR_W-1:0] addr, input logic [MGMT_DATA_W-1:0] data);
	@(posedge clk);
	#1;
	wr_en = 1'b1;
	wr_addr = addr;
	wr_data = data;
endtask

// Drop the strobe right after the edge that took the write
task automatic release_write();
	@(posedge clk);
	#1;
	wr_en = 1'b0;
endtask

// One cycle read strobe, data is registered on the same edge that ends it
task automatic drive_read(input logic [MGMT_ADDR_W-1:0] addr, output logic [MGMT_DATA_W-1:0] data);
	@(posedge clk);
	#1;
	rd_en = 1'b1;
	rd_addr = addr;
	@(posedge clk);
	#1;
	rd_en = 1'b0;
	data = rd_data;
endtask

//////////////////////
// Typed compares

task automatic check_byte(input string name, input logic [MGMT_DATA_W-1:0] got,
		input logic [MGMT_DATA_W-1:0] exp);
	if (got !== exp) begin
		$display("mismatch at %0d ns: %s got %h expected %h", $time, name, got, exp);
		report_failure();
	end
endtask

task automatic check_drp_word(input string name, input logic [DRP_DATA_W-1:0] got,
		input logic [DRP_DATA_W-1:0] exp);
	if (got !== exp) begin
		$display("mismatch at %0d ns: %s got %h expected %h", $time, name, got, exp);
		report_failure();
	end
endtask

task automatic check_txcfg(input string name, input lane_txconfig_t got, input lane_txconfig_t exp);
	if (got !== exp) begin
		$display("mismatch at %0d ns: %s got %h expected %h", $time, name, got, exp);
		report_failure();
	end
endtask

task automatic check_rxcfg(input string name, input lane_rxconfig_t got, input lane_rxconfig_t exp);
	if (got !== exp) begin
		$display("mismatch at %0d ns: %s got %h expected %h", $time, name, got, exp);
		report_failure();
	end
endtask

task automatic check_muxsel(input string name, input logic [MUXSEL_W-1:0] got,
		input logic [MUXSEL_W-1:0] exp);
	if (got !== exp) begin
		$display("mismatch at %0d ns: %s got %h expected %h", $time, name, got, exp);
		report_failure();
	end
endtask

`endif

// File: verification/tb_mgmt_register_block.sv
`timescale 1ns/1ps

module tb_mgmt_register_block
	import mgmt_regmap_pkg::*, bert_lane_pkg::*;
();

	typedef enum int {
		OP_WRITE, OP_READ, OP_WAIT_DRP, OP_WAIT_RELAY, OP_READ_RDATA, OP_RSTDONE
	} op_t;

	typedef struct {
		op_t                    op;
		logic [MGMT_ADDR_W-1:0] addr;
		logic [MGMT_DATA_W-1:0] data;
		logic [MGMT_DATA_W-1:0] exp;
	} row_t;

	logic                       clk = 1'b0;
	logic                       rst;
	logic                       rd_en;
	logic [MGMT_ADDR_W-1:0]     rd_addr;
	logic                       rd_valid;
	logic [MGMT_DATA_W-1:0]     rd_data;
	logic                       wr_en;
	logic [MGMT_ADDR_W-1:0]     wr_addr;
	logic [MGMT_DATA_W-1:0]     wr_data;
	lane_txconfig_t             tx_config [NUM_LANES];
	lane_rxconfig_t             rx_config [NUM_LANES];
	logic [NUM_LANES-1:0]       config_updated;
	logic [NUM_LANES-1:0]       drp_en;
	logic [NUM_LANES-1:0]       drp_we;
	logic [DRP_ADDR_W-1:0]      drp_addr [NUM_LANES];
	logic [DRP_DATA_W-1:0]      drp_wdata [NUM_LANES];
	logic [DRP_DATA_W-1:0]      drp_rdata [NUM_LANES];
	logic [NUM_LANES-1:0]       drp_done;
	logic [NUM_LANES-1:0]       rx_rstdone;
	logic [MUXSEL_W-1:0]        muxsel [NUM_MUX_CHANNELS];
	logic                       relay_en;
	logic                       relay_dir;
	logic [RELAY_CHANNEL_W-1:0] relay_channel;
	logic                       relay_done = 1'b0;

	// Model state and expected register contents
	logic [31:0]                rng_state = 32'd59165;
	logic [DRP_DATA_W-1:0]      model_rdata [NUM_LANES];
	logic                       relay_outstanding = 1'b0;
	logic [MGMT_DATA_W-1:0]     lane_shadow [NUM_LANES][LANE_WINDOW];
	logic [MUXSEL_W-1:0]        mux_shadow [NUM_MUX_CHANNELS];
	logic [RELAY_CHANNEL_W-1:0] channel_shadow;
	logic                       rd_en_prev;
	row_t                       table_q [$];

	mgmt_register_block DUT (.*);

	always #5 clk = ~clk;

	task automatic report_failure();
		$display("Finished with errors");
		$fatal(1, "testbench stopped at the first error");
	endtask

	`include "tb_mgmt_checks.svh"

	//////////////////////
	// Transceiver models

	// Each lane answers its own DRP access after 1 to 8 cycles
	for (genvar g = 0; g < NUM_LANES; g++) begin : g_drp_model
		logic                  done_q = 1'b0;
		logic [DRP_DATA_W-1:0] rdata_q = '0;

		assign drp_done[g] = done_q;
		assign drp_rdata[g] = rdata_q;

		always @(posedge clk) begin : respond
			int          d;
			logic [31:0] r;
			if (!rst && drp_en[g]) begin
				d = 1 + int'(next_rand() % 8);
				r = next_rand();
				repeat (d) @(posedge clk);
				#1;
				rdata_q = r[DRP_DATA_W-1:0];
				model_rdata[g] = r[DRP_DATA_W-1:0];
				done_q = 1'b1;
				@(posedge clk);
				#1;
				done_q = 1'b0;
			end
		end
	end

	// Coil settle of 3 cycles, then 1 to 8 random cycles
	always @(posedge clk) begin : relay_model
		int d;
		if (!rst && relay_en) begin
			relay_outstanding = 1'b1;
			d = 4 + int'(next_rand() % 8);
			repeat (d) @(posedge clk);
			#1;
			relay_done = 1'b1;
			@(posedge clk);
			// DUT drops busy on this same edge
			relay_outstanding = 1'b0;
			#1;
			relay_done = 1'b0;
		end
	end

	// rd_valid follows rd_en by exactly one cycle
	always @(posedge clk) begin
		rd_en_prev = rd_en;
		#2;
		if (!rst)
			check_byte("rd_valid", {7'b0, rd_valid}, {7'b0, rd_en_prev});
	end

	//////////////////////
	// Expected values

	function automatic int lane_of(input logic [MGMT_ADDR_W-1:0] addr);
		if (addr >= 16'h0080 && addr < 16'h00a0)
			return 0;
		if (addr >= 16'h00a0 && addr < 16'h00c0)
			return 1;
		return -1;
	endfunction

	// Driver word bytes 0x02/0x03, PRBS high nibble, CLK low nibble, RST bit 1
	function automatic lane_txconfig_t expect_tx(input int l);
		lane_txconfig_t t;
		logic [15:0]    w;
		w = {lane_shadow[l][3], lane_shadow[l][2]};
		t.prbsmode = lane_shadow[l][0][6:4];
		t.swing = w[3:0];
		t.precursor = w[8:4];
		t.postcursor = w[13:9];
		t.enable = w[14];
		t.invert = w[15];
		t.clkdiv = lane_shadow[l][12][2:0];
		t.clk_from_qpll = lane_shadow[l][12][3];
		t.tx_reset = lane_shadow[l][14][1];
		return t;
	endfunction

	function automatic lane_rxconfig_t expect_rx(input int l);
		lane_rxconfig_t t;
		t.prbsmode = lane_shadow[l][0][2:0];
		t.clkdiv = lane_shadow[l][12][6:4];
		t.clk_from_qpll = lane_shadow[l][12][7];
		t.pmareset = lane_shadow[l][14][0];
		t.rx_reset = lane_shadow[l][14][2];
		t.invert = lane_shadow[l][16][0];
		return t;
	endfunction

	task automatic check_all_config();
		for (int l = 0; l < NUM_LANES; l++) begin
			check_txcfg($sformatf("tx_config[%0d]", l), tx_config[l], expect_tx(l));
			check_rxcfg($sformatf("rx_config[%0d]", l), rx_config[l], expect_rx(l));
		end
		for (int i = 0; i < NUM_MUX_CHANNELS; i++)
			check_muxsel($sformatf("muxsel[%0d]", i), muxsel[i], mux_shadow[i]);
	endtask

	// Write, then check the strobes and outputs one cycle later
	task automatic write_and_check(input logic [MGMT_ADDR_W-1:0] addr,
			input logic [MGMT_DATA_W-1:0] data);
		int                   l;
		logic [4:0]           off;
		logic [NUM_LANES-1:0] exp_cfg;
		logic [NUM_LANES-1:0] exp_drp;
		logic                 exp_relay;
		exp_cfg = '0;
		exp_drp = '0;
		l = lane_of(addr);
		off = addr[4:0];
		drive_write(addr, data);
		// Busy as the relay sees it in the cycle the write is taken
		exp_relay = (addr == 16'h0071) && !relay_outstanding;
		if (l >= 0) begin
			lane_shadow[l][off] = data;
			if (off inside {5'h00, 5'h03, 5'h0c, 5'h0e, 5'h10})
				exp_cfg[l] = 1'b1;
			if (off == 5'h07)
				exp_drp[l] = 1'b1;
		end
		if (addr >= 16'h00f0 && addr < 16'h00fc)
			mux_shadow[int'(addr - 16'h00f0)] = data[3:0];
		if (addr == 16'h0070)
			channel_shadow = data[1:0];
		release_write();
		check_byte("config_updated", {6'b0, config_updated}, {6'b0, exp_cfg});
		check_byte("drp_en", {6'b0, drp_en}, {6'b0, exp_drp});
		check_byte("relay_en", {7'b0, relay_en}, {7'b0, exp_relay});
		if (exp_relay) begin
			check_byte("relay_dir", {7'b0, relay_dir}, {7'b0, data[7]});
			check_byte("relay_channel", {6'b0, relay_channel}, {6'b0, channel_shadow});
		end
		for (int i = 0; i < NUM_LANES; i++) begin
			if (exp_drp[i]) begin
				check_byte("drp_we", {7'b0, drp_we[i]}, {7'b0, lane_shadow[i][7][7]});
				check_drp_word("drp_addr", {7'b0, drp_addr[i]},
					{7'b0, lane_shadow[i][7][0], lane_shadow[i][6]});
				check_drp_word("drp_wdata", drp_wdata[i], {lane_shadow[i][5], lane_shadow[i][4]});
			end
		end
		check_all_config();
	endtask

	// Poll a status byte until bit 0 clears
	task automatic wait_idle(input logic [MGMT_ADDR_W-1:0] addr, input string what);
		logic [MGMT_DATA_W-1:0] got;
		int                     tries;
		tries = 0;
		got = 8'h01;
		while (got[0] && tries < 40) begin
			drive_read(addr, got);
			tries++;
		end
		if (got[0]) begin
			$display("timeout waiting for %s done at %0d ns", what, $time);
			report_failure();
		end
	endtask

	task automatic add_row(input op_t op, input logic [15:0] addr, input logic [7:0] data,
			input logic [7:0] exp);
		row_t r;
		r.op = op;
		r.addr = addr;
		r.data = data;
		r.exp = exp;
		table_q.push_back(r);
	endtask

	task automatic build_table();
		// Status and unmapped space after reset
		add_row(OP_READ, 16'h008a, 8'h00, 8'h00);
		add_row(OP_READ, 16'h00aa, 8'h00, 8'h00);
		add_row(OP_READ, 16'h0000, 8'h00, 8'h00);
		add_row(OP_READ, 16'h0075, 8'h00, 8'h00);
		add_row(OP_READ, 16'h0100, 8'h00, 8'h00);
		// Lane 0 config fields
		add_row(OP_WRITE, 16'h0080, 8'h53, 8'h00);
		add_row(OP_WRITE, 16'h0082, 8'ha7, 8'h00);
		add_row(OP_WRITE, 16'h0083, 8'hc5, 8'h00);
		add_row(OP_WRITE, 16'h008c, 8'hbd, 8'h00);
		add_row(OP_WRITE, 16'h008e, 8'h07, 8'h00);
		add_row(OP_WRITE, 16'h0090, 8'h01, 8'h00);
		// Lane 1 config fields, plus an offset with no register
		add_row(OP_WRITE, 16'h00a0, 8'h61, 8'h00);
		add_row(OP_WRITE, 16'h00a2, 8'h3c, 8'h00);
		add_row(OP_WRITE, 16'h00a3, 8'h5a, 8'h00);
		add_row(OP_WRITE, 16'h00ac, 8'h42, 8'h00);
		add_row(OP_WRITE, 16'h00ae, 8'h02, 8'h00);
		add_row(OP_WRITE, 16'h00b0, 8'h01, 8'h00);
		add_row(OP_WRITE, 16'h00b1, 8'hff, 8'h00);
		// DRP write on lane 0
		add_row(OP_WRITE, 16'h0084, 8'h34, 8'h00);
		add_row(OP_WRITE, 16'h0085, 8'h12, 8'h00);
		add_row(OP_WRITE, 16'h0086, 8'h9e, 8'h00);
		add_row(OP_WRITE, 16'h0087, 8'h81, 8'h00);
		add_row(OP_READ, 16'h008a, 8'h00, 8'h01);
		add_row(OP_WAIT_DRP, 16'h008a, 8'h00, 8'h00);
		add_row(OP_READ, 16'h008a, 8'h00, 8'h00);
		add_row(OP_READ_RDATA, 16'h0088, 8'h00, 8'h00);
		add_row(OP_READ_RDATA, 16'h0089, 8'h00, 8'h00);
		// DRP read on lane 1
		add_row(OP_WRITE, 16'h00a4, 8'hef, 8'h00);
		add_row(OP_WRITE, 16'h00a5, 8'hbe, 8'h00);
		add_row(OP_WRITE, 16'h00a6, 8'h20, 8'h00);
		add_row(OP_WRITE, 16'h00a7, 8'h00, 8'h00);
		add_row(OP_READ, 16'h00aa, 8'h00, 8'h01);
		add_row(OP_WAIT_DRP, 16'h00aa, 8'h00, 8'h00);
		add_row(OP_READ_RDATA, 16'h00a8, 8'h00, 8'h00);
		add_row(OP_READ_RDATA, 16'h00a9, 8'h00, 8'h00);
		// Receiver reset done shows in STAT bit 1 of its own lane only
		add_row(OP_RSTDONE, 16'h0000, 8'h02, 8'h00);
		add_row(OP_READ, 16'h00aa, 8'h00, 8'h02);
		add_row(OP_READ, 16'h008a, 8'h00, 8'h00);
		add_row(OP_RSTDONE, 16'h0000, 8'h00, 8'h00);
		// Selector bank
		add_row(OP_WRITE, 16'h00f0, 8'h3a, 8'h00);
		add_row(OP_WRITE, 16'h00f5, 8'h0c, 8'h00);
		add_row(OP_WRITE, 16'h00fb, 8'hf7, 8'h00);
		add_row(OP_WRITE, 16'h00f5, 8'h06, 8'h00);
		add_row(OP_READ, 16'h00f5, 8'h00, 8'h06);
		add_row(OP_READ, 16'h00fb, 8'h00, 8'h07);
		add_row(OP_READ, 16'h00fc, 8'h00, 8'h00);
		// Relay, second toggle lands while busy
		add_row(OP_WRITE, 16'h0070, 8'h02, 8'h00);
		add_row(OP_WRITE, 16'h0071, 8'h80, 8'h00);
		add_row(OP_WRITE, 16'h0071, 8'h00, 8'h00);
		add_row(OP_READ, 16'h0073, 8'h00, 8'h01);
		add_row(OP_WAIT_RELAY, 16'h0073, 8'h00, 8'h00);
		add_row(OP_READ, 16'h0073, 8'h00, 8'h00);
		add_row(OP_WRITE, 16'h0070, 8'h01, 8'h00);
		add_row(OP_WRITE, 16'h0071, 8'h00, 8'h00);
		add_row(OP_WAIT_RELAY, 16'h0073, 8'h00, 8'h00);
	endtask

	//////////////////////
	// Main sequence

	initial begin : main
		logic [MGMT_DATA_W-1:0] got;
		int                     l;
		rst = 1'b1;
		rd_en = 1'b0;
		rd_addr = '0;
		wr_en = 1'b0;
		wr_addr = '0;
		wr_data = '0;
		rx_rstdone = '0;
		channel_shadow = '0;
		for (int i = 0; i < NUM_LANES; i++) begin
			model_rdata[i] = '0;
			for (int j = 0; j < LANE_WINDOW; j++)
				lane_shadow[i][j] = '0;
		end
		for (int i = 0; i < NUM_MUX_CHANNELS; i++)
			mux_shadow[i] = '0;
		build_table();

		repeat (4) @(posedge clk);
		#1;
		rst = 1'b0;

		// Everything idle and zero out of reset
		check_all_config();
		check_byte("config_updated", {6'b0, config_updated}, 8'h00);
		check_byte("drp_en", {6'b0, drp_en}, 8'h00);
		check_byte("relay_en", {7'b0, relay_en}, 8'h00);
		check_byte("rd_valid", {7'b0, rd_valid}, 8'h00);

		foreach (table_q[i]) begin
			case (table_q[i].op)
				OP_WRITE:
					write_and_check(table_q[i].addr, table_q[i].data);
				OP_READ: begin
					drive_read(table_q[i].addr, got);
					check_byte($sformatf("rd_data@%h", table_q[i].addr), got, table_q[i].exp);
				end
				OP_WAIT_DRP:
					wait_idle(table_q[i].addr, "DRP");
				OP_WAIT_RELAY:
					wait_idle(table_q[i].addr, "relay");
				OP_READ_RDATA: begin
					l = lane_of(table_q[i].addr);
					drive_read(table_q[i].addr, got);
					if (table_q[i].addr[0])
						check_byte("drp read back", got, model_rdata[l][15:8]);
					else
						check_byte("drp read back", got, model_rdata[l][7:0]);
				end
				// One flag bit per lane
				OP_RSTDONE:
					rx_rstdone = table_q[i].data[NUM_LANES-1:0];
				default: begin
				end
			endcase
		end

		repeat (2) @(posedge clk);
		$display("Finished with no errors");
		$finish;
	end

endmodule
